//--- Makefile
SIM := obj_dir/Vnetapp_echo_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and search sim.log for the pass line"
	@echo "  clean  remove the build directory and sim.log"

$(SIM): flist.f $(wildcard source/*) $(wildcard bench/*)
	verilator --binary --assert --timing --top-module netapp_echo_tb -f flist.f

test: $(SIM)
	./$(SIM) +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/netapp_echo_properties.sv
`default_nettype none

// protocol checks on the listen and transmit interfaces of the echo top level
module netapp_echo_properties (
   input logic                  clk,
   input logic                  aresetn,
   input logic                  listen_port_valid,
   input logic                  tx_data_valid,
   input logic                  tx_data_ready,
   input netapp_pkg::net_beat_t tx_data,
   input logic                  tx_meta_valid,
   input logic                  tx_meta_ready,
   input netapp_pkg::session_t  tx_meta
);

   int   fail_count = 0;
   logic at_first;

   // follows packet boundaries on tx_data so that a first beat can be told apart
   always_ff @(posedge clk) begin
      if (!aresetn) begin
         at_first <= 1'b1;
      end else if (tx_data_valid && tx_data_ready) begin
         at_first <= tx_data.last;
      end
   end

   // --------------------
   // transmit side
   // --------------------
   first_beat_waits: assert property (@(posedge clk) disable iff (!aresetn)
      tx_data_valid && tx_data_ready && at_first |-> tx_meta_ready)
   else begin
      fail_count++;
      $error("first beat of a packet left while tx_meta_ready was low");
   end

   meta_holds: assert property (@(posedge clk) disable iff (!aresetn)
      tx_meta_valid && !tx_meta_ready |=> tx_meta_valid && $stable(tx_meta))
   else begin
      fail_count++;
      $error("tx_meta word changed or dropped before it was accepted");
   end

   // a waiting first beat may lose valid when tx_meta_ready drops, its data still holds
   data_holds: assert property (@(posedge clk) disable iff (!aresetn)
      tx_data_valid && !tx_data_ready |=> $stable(tx_data) && (at_first || tx_data_valid))
   else begin
      fail_count++;
      $error("tx_data changed or dropped while it waited for ready");
   end

   // --------------------
   // reset
   // --------------------
   quiet_after_reset: assert property (@(posedge clk)
      $rose(aresetn) |-> !listen_port_valid && !tx_data_valid && !tx_meta_valid)
   else begin
      fail_count++;
      $error("an output valid was high in the cycle after reset");
   end

endmodule

bind netapp_echo_top netapp_echo_properties props_i (
   .clk               (clk),
   .aresetn           (aresetn),
   .listen_port_valid (listen_port_valid),
   .tx_data_valid     (tx_data_valid),
   .tx_data_ready     (tx_data_ready),
   .tx_data           (tx_data),
   .tx_meta_valid     (tx_meta_valid),
   .tx_meta_ready     (tx_meta_ready),
   .tx_meta           (tx_meta)
);

`default_nettype wire

//--- bench/netapp_echo_tb.sv
`default_nettype none

`include "netapp_macros.svh"

module netapp_echo_tb;

   localparam int NUM_PKTS    = 24;
   localparam int MAX_BEATS   = 8;
   localparam int NUM_PORTS   = `NETAPP_PORT_END - `NETAPP_PORT_FIRST;
   // four cycles per beat at worst, with room for reset and the drain
   localparam int CYCLE_LIMIT = NUM_PKTS * MAX_BEATS * 4 + 200;

   logic                      clk;
   logic                      aresetn;
   logic                      listen_port_valid;
   logic                      listen_port_ready;
   logic [`NETAPP_PORT_W-1:0] listen_port_data;
   logic                      rx_data_valid;
   logic                      rx_data_ready;
   netapp_pkg::net_beat_t     rx_data;
   logic                      rx_meta_valid;
   logic                      rx_meta_ready;
   netapp_pkg::session_t      rx_meta;
   logic                      tx_data_valid;
   logic                      tx_data_ready;
   netapp_pkg::net_beat_t     tx_data;
   logic                      tx_meta_valid;
   logic                      tx_meta_ready;
   netapp_pkg::session_t      tx_meta;

   // stimulus still to send and the scoreboard of what must come back
   netapp_pkg::net_beat_t stim_beats[$];
   netapp_pkg::session_t  stim_sessions[$];
   netapp_pkg::net_beat_t exp_beats[$];
   netapp_pkg::session_t  exp_sessions[$];

   int   errors      = 0;
   int   cycles      = 0;
   int   beats_out   = 0;
   int   pkts_out    = 0;
   int   metas_out   = 0;
   int   strobes     = 0;
   int   total_beats = 0;
   logic strobe_prev;
   logic tx_first;

   netapp_echo_top dut_i (
      .clk               (clk),
      .aresetn           (aresetn),
      .listen_port_valid (listen_port_valid),
      .listen_port_ready (listen_port_ready),
      .listen_port_data  (listen_port_data),
      .rx_data_valid     (rx_data_valid),
      .rx_data_ready     (rx_data_ready),
      .rx_data           (rx_data),
      .rx_meta_valid     (rx_meta_valid),
      .rx_meta_ready     (rx_meta_ready),
      .rx_meta           (rx_meta),
      .tx_data_valid     (tx_data_valid),
      .tx_data_ready     (tx_data_ready),
      .tx_data           (tx_data),
      .tx_meta_valid     (tx_meta_valid),
      .tx_meta_ready     (tx_meta_ready),
      .tx_meta           (tx_meta)
   );

   always #2 clk = ~clk;

   task automatic flag_mismatch(input string msg);
      errors++;
      $display("MISMATCH at %0t: %s", $time, msg);
   endtask

   task automatic finish_run(input bit timed_out);
      int prop_fails;
      prop_fails = dut_i.props_i.fail_count;
      $display("%0d mismatches, %0d property fails, %0d/%0d beats, %0d/%0d meta, %0d strobes",
               errors, prop_fails, beats_out, total_beats, metas_out, NUM_PKTS, strobes);
      if (timed_out || errors != 0 || prop_fails != 0) begin
         $display("CHECKS FAILED");
      end else begin
         $display("ALL CHECKS PASSED");
      end
      $finish;
   endtask

   task automatic build_packets();
      int                    len;
      netapp_pkg::net_beat_t beat;
      netapp_pkg::session_t  session;
      for (int p = 0; p < NUM_PKTS; p++) begin
         len     = 1 + ($urandom % MAX_BEATS);
         session = netapp_pkg::session_t'($urandom);
         stim_sessions.push_back(session);
         exp_sessions.push_back(session);
         for (int i = 0; i < len; i++) begin
            beat.data = {$urandom, $urandom};
            beat.last = (i == len - 1);
            stim_beats.push_back(beat);
            exp_beats.push_back(beat);
            total_beats++;
         end
      end
   endtask

   // --------------------
   // receive side drivers
   // --------------------
   task automatic drive_rx_data();
      bit accepted;
      while (stim_beats.size() > 0) begin
         if ($urandom % 4 == 0) begin
            rx_data_valid = 1'b0;
            repeat (1 + $urandom % 3) @(negedge clk);
         end
         rx_data_valid = 1'b1;
         rx_data       = stim_beats.pop_front();
         accepted      = 1'b0;
         while (!accepted) begin
            @(posedge clk);
            accepted = rx_data_ready;
            @(negedge clk);
         end
      end
      rx_data_valid = 1'b0;
   endtask

   // metadata runs on its own so it lands before, with or after its packet
   task automatic drive_rx_meta();
      bit accepted;
      while (stim_sessions.size() > 0) begin
         rx_meta_valid = 1'b0;
         repeat ($urandom % 6) @(negedge clk);
         rx_meta_valid = 1'b1;
         rx_meta       = stim_sessions.pop_front();
         accepted      = 1'b0;
         while (!accepted) begin
            @(posedge clk);
            accepted = rx_meta_ready;
            @(negedge clk);
         end
      end
      rx_meta_valid = 1'b0;
   endtask

   // random back-pressure, low about a third of the time
   always @(negedge clk) begin
      tx_data_ready     = ($urandom % 3) != 0;
      tx_meta_ready     = ($urandom % 3) != 0;
      listen_port_ready = ($urandom % 3) != 0;
   end

   // --------------------
   // output monitor
   // --------------------
   always @(posedge clk) begin
      netapp_pkg::net_beat_t exp_beat;
      netapp_pkg::session_t  exp_session;
      if (!aresetn) begin
         strobe_prev = 1'b0;
         tx_first    = 1'b1;
      end else begin
         if (listen_port_valid) begin
            assert (strobes < NUM_PORTS) else flag_mismatch("listen strobe after the last port");
            assert (!strobe_prev) else flag_mismatch("listen strobes in adjacent cycles");
            assert (listen_port_data == `NETAPP_PORT_W'(`NETAPP_PORT_FIRST + strobes))
               else flag_mismatch($sformatf("listen port %0d, expected %0d",
                                            listen_port_data, `NETAPP_PORT_FIRST + strobes));
            strobes++;
         end
         strobe_prev = listen_port_valid;
         // the metadata word goes first, it may leave on the edge that starts the next packet
         if (tx_meta_valid && tx_meta_ready) begin
            assert (metas_out < pkts_out) else flag_mismatch("tx_meta word ahead of its packet");
            assert (exp_sessions.size() > 0)
               else flag_mismatch("tx_meta word after the last packet");
            if (exp_sessions.size() > 0) begin
               exp_session = exp_sessions.pop_front();
               assert (tx_meta == exp_session)
                  else flag_mismatch($sformatf("tx_meta %h, expected %h", tx_meta, exp_session));
            end
            metas_out++;
         end
         if (tx_data_valid && tx_data_ready) begin
            if (tx_first) begin
               assert (metas_out == pkts_out)
                  else flag_mismatch("packet started while the previous tx_meta word was missing");
               pkts_out++;
            end
            assert (exp_beats.size() > 0) else flag_mismatch("tx_data beat after the last packet");
            if (exp_beats.size() > 0) begin
               exp_beat = exp_beats.pop_front();
               assert (tx_data == exp_beat)
                  else flag_mismatch($sformatf("tx_data beat %0d is %h, expected %h",
                                               beats_out, tx_data, exp_beat));
            end
            tx_first = tx_data.last;
            beats_out++;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: traffic did not drain within %0d cycles", CYCLE_LIMIT);
         finish_run(1'b1);
      end
   end

   initial begin
      void'($urandom(32'h9a7c));
      clk               = 1'b0;
      aresetn           = 1'b0;
      listen_port_ready = 1'b0;
      rx_data_valid     = 1'b0;
      rx_data           = '0;
      rx_meta_valid     = 1'b0;
      rx_meta           = '0;
      tx_data_ready     = 1'b0;
      tx_meta_ready     = 1'b0;
      build_packets();
      repeat (2) @(negedge clk);
      aresetn = 1'b1;
      fork
         drive_rx_data();
         drive_rx_meta();
      join
      while (beats_out < total_beats || metas_out < NUM_PKTS || strobes < NUM_PORTS) begin
         @(negedge clk);
      end
      // a few idle cycles to catch stray strobes or beats
      repeat (10) @(negedge clk);
      finish_run(1'b0);
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+source
source/netapp_pkg.sv
source/stream_fifo.sv
source/listen_port_opener.sv
source/rx_session_tagger.sv
source/tx_splitter.sv
source/netapp_echo_top.sv
bench/netapp_echo_properties.sv
bench/netapp_echo_tb.sv

//--- source/listen_port_opener.sv
`default_nettype none

`include "netapp_macros.svh"

// offers each server port of the fixed range once after reset
module listen_port_opener (
   input  logic                      clk,
   input  logic                      aresetn,
   input  logic                      listen_port_ready,
   output logic                      listen_port_valid,
   output logic [`NETAPP_PORT_W-1:0] listen_port_data
);

   logic [`NETAPP_PORT_W-1:0] next_port;
   logic                      ports_left;
   logic                      issue;

   assign ports_left = (next_port < `NETAPP_PORT_W'(`NETAPP_PORT_END));

   // ready only gates the start, the strobe itself never waits for it
   assign issue = ~listen_port_valid & listen_port_ready & ports_left;

   always_ff @(posedge clk) begin
      if (!aresetn) begin
         listen_port_valid <= 1'b0;
         next_port         <= `NETAPP_PORT_W'(`NETAPP_PORT_FIRST);
      end else begin
         listen_port_valid <= issue;
         if (issue) begin
            next_port <= next_port + 1'b1;
         end
      end
   end

   // port number register, only looked at while the strobe is high
   always_ff @(posedge clk) begin
      if (issue) begin
         listen_port_data <= next_port;
      end
   end

endmodule

`default_nettype wire

//--- source/netapp_echo_top.sv
`default_nettype none

`include "netapp_macros.svh"

// echo server, each received packet goes back out on its own session
module netapp_echo_top (
   input  logic                      clk,
   input  logic                      aresetn,
   // --------------------
   // listen port requests
   // --------------------
   output logic                      listen_port_valid,
   input  logic                      listen_port_ready,
   output logic [`NETAPP_PORT_W-1:0] listen_port_data,
   // --------------------
   // receive side
   // --------------------
   input  logic                      rx_data_valid,
   output logic                      rx_data_ready,
   input  netapp_pkg::net_beat_t     rx_data,
   input  logic                      rx_meta_valid,
   output logic                      rx_meta_ready,
   input  netapp_pkg::session_t      rx_meta,
   // --------------------
   // transmit side
   // --------------------
   output logic                      tx_data_valid,
   input  logic                      tx_data_ready,
   output netapp_pkg::net_beat_t     tx_data,
   output logic                      tx_meta_valid,
   input  logic                      tx_meta_ready,
   output netapp_pkg::session_t      tx_meta
);

   // rx buffer output
   logic                  rxq_valid;
   logic                  rxq_ready;
   netapp_pkg::net_beat_t rxq_beat;

   // loopback between the tagger and the tx buffer
   logic                  tagged_valid;
   logic                  tagged_ready;
   netapp_pkg::tx_beat_t  tagged_beat;

   // tx buffer output
   logic                  txq_valid;
   logic                  txq_ready;
   netapp_pkg::tx_beat_t  txq_beat;

   listen_port_opener opener_i (
      .clk               (clk),
      .aresetn           (aresetn),
      .listen_port_ready (listen_port_ready),
      .listen_port_valid (listen_port_valid),
      .listen_port_data  (listen_port_data)
   );

   stream_fifo #(
      .payload_t (netapp_pkg::net_beat_t),
      .ADDR_BITS (`NETAPP_RX_FIFO_ABITS)
   ) rx_fifo_i (
      .clk       (clk),
      .aresetn   (aresetn),
      .in_valid  (rx_data_valid),
      .in_ready  (rx_data_ready),
      .in_data   (rx_data),
      .out_valid (rxq_valid),
      .out_ready (rxq_ready),
      .out_data  (rxq_beat)
   );

   rx_session_tagger tagger_i (
      .clk           (clk),
      .aresetn       (aresetn),
      .rx_meta_valid (rx_meta_valid),
      .rx_meta_ready (rx_meta_ready),
      .rx_meta       (rx_meta),
      .in_valid      (rxq_valid),
      .in_ready      (rxq_ready),
      .in_beat       (rxq_beat),
      .out_valid     (tagged_valid),
      .out_ready     (tagged_ready),
      .out_beat      (tagged_beat)
   );

   stream_fifo #(
      .payload_t (netapp_pkg::tx_beat_t),
      .ADDR_BITS (`NETAPP_TX_FIFO_ABITS)
   ) tx_fifo_i (
      .clk       (clk),
      .aresetn   (aresetn),
      .in_valid  (tagged_valid),
      .in_ready  (tagged_ready),
      .in_data   (tagged_beat),
      .out_valid (txq_valid),
      .out_ready (txq_ready),
      .out_data  (txq_beat)
   );

   tx_splitter splitter_i (
      .clk           (clk),
      .aresetn       (aresetn),
      .in_valid      (txq_valid),
      .in_ready      (txq_ready),
      .in_beat       (txq_beat),
      .tx_data_valid (tx_data_valid),
      .tx_data_ready (tx_data_ready),
      .tx_data       (tx_data),
      .tx_meta_valid (tx_meta_valid),
      .tx_meta_ready (tx_meta_ready),
      .tx_meta       (tx_meta)
   );

endmodule

`default_nettype wire

//--- source/netapp_macros.svh
`ifndef NETAPP_MACROS_SVH
`define NETAPP_MACROS_SVH

// --------------------
// stream widths
// --------------------
`define NETAPP_DATA_W 64
`define NETAPP_SESSION_W 16
`define NETAPP_PORT_W 16

// the server listens on ports 2880 up to and including 2887
`define NETAPP_PORT_FIRST 2880
`define NETAPP_PORT_END 2888

// --------------------
// buffer depths as address bits
// --------------------
`define NETAPP_RX_FIFO_ABITS 5
`define NETAPP_TX_FIFO_ABITS 4

`endif

//--- source/netapp_pkg.sv
`default_nettype none

`include "netapp_macros.svh"

package netapp_pkg;

   // session number as carried on the rx and tx metadata streams
   typedef logic [`NETAPP_SESSION_W-1:0] session_t;

   // --------------------
   // network side beat
   // --------------------
   // full 8-byte beats only, so no keep field travels with the data
   typedef struct packed {
      logic                      last;
      logic [`NETAPP_DATA_W-1:0] data;
   } net_beat_t;

   // --------------------
   // transmit side beat
   // --------------------
   // every beat carries its session, only the first one of a packet is used
   typedef struct packed {
      logic                      last;
      session_t                  session;
      logic [`NETAPP_DATA_W-1:0] data;
   } tx_beat_t;

endpackage

`default_nettype wire

//--- source/rx_session_tagger.sv
`default_nettype none

// attaches the session of each received packet to all of its beats
module rx_session_tagger (
   input  logic                 clk,
   input  logic                 aresetn,
   // --------------------
   // receive metadata, one word per packet
   // --------------------
   input  logic                 rx_meta_valid,
   output logic                 rx_meta_ready,
   input  netapp_pkg::session_t rx_meta,
   // --------------------
   // buffered receive beats
   // --------------------
   input  logic                 in_valid,
   output logic                 in_ready,
   input  netapp_pkg::net_beat_t in_beat,
   // --------------------
   // tagged beats towards the tx buffer
   // --------------------
   output logic                 out_valid,
   input  logic                 out_ready,
   output netapp_pkg::tx_beat_t out_beat
);

   logic                 held;
   netapp_pkg::session_t session;
   logic                 meta_take;
   logic                 beat_take;

   // a new session is only taken between packets
   assign rx_meta_ready = ~held;
   assign meta_take     = rx_meta_valid & rx_meta_ready;

   // beats wait here until their packet's session has arrived
   assign out_valid = in_valid & held;
   assign in_ready  = out_ready & held;
   assign beat_take = in_valid & in_ready;

   assign out_beat.last    = in_beat.last;
   assign out_beat.session = session;
   assign out_beat.data    = in_beat.data;

   always_ff @(posedge clk) begin
      if (!aresetn) begin
         held <= 1'b0;
      end else if (meta_take) begin
         held <= 1'b1;
      end else if (beat_take && in_beat.last) begin
         held <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (meta_take) begin
         session <= rx_meta;
      end
   end

endmodule

`default_nettype wire

//--- source/stream_fifo.sv
`default_nettype none

// circular buffer with a fall-through head
module stream_fifo #(
   parameter type payload_t = logic,
   parameter int  ADDR_BITS = 4
) (
   input  logic     clk,
   input  logic     aresetn,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   localparam int DEPTH = 1 << ADDR_BITS;

   payload_t mem [DEPTH];

   logic [ADDR_BITS-1:0] wr_ptr;
   logic [ADDR_BITS-1:0] rd_ptr;
   logic [ADDR_BITS:0]   count;
   logic                 push;
   logic                 pop;

   // the count tops out at DEPTH, so its upper bit is the full flag
   assign in_ready  = ~count[ADDR_BITS];
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!aresetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // a push and a pop in one cycle leave the count as it is
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/tx_splitter.sv
`default_nettype none

// turns the tagged transmit stream into data beats and one metadata word per packet
module tx_splitter (
   input  logic                  clk,
   input  logic                  aresetn,
   input  logic                  in_valid,
   output logic                  in_ready,
   input  netapp_pkg::tx_beat_t  in_beat,
   output logic                  tx_data_valid,
   input  logic                  tx_data_ready,
   output netapp_pkg::net_beat_t tx_data,
   output logic                  tx_meta_valid,
   input  logic                  tx_meta_ready,
   output netapp_pkg::session_t  tx_meta
);

   logic first;
   logic meta_ok;
   logic take;

   // the first beat of a packet only moves once the metadata side can take a word
   assign meta_ok = ~first | tx_meta_ready;

   assign tx_data_valid = in_valid & meta_ok;
   assign in_ready      = tx_data_ready & meta_ok;
   assign take          = in_valid & in_ready;

   // the session is dropped from the outgoing beats
   assign tx_data.last = in_beat.last;
   assign tx_data.data = in_beat.data;

   always_ff @(posedge clk) begin
      if (!aresetn) begin
         first         <= 1'b1;
         tx_meta_valid <= 1'b0;
      end else begin
         if (tx_meta_valid && tx_meta_ready) begin
            tx_meta_valid <= 1'b0;
         end
         // a new word overrides the clear above, the old one left on this same edge
         if (take && first) begin
            tx_meta_valid <= 1'b1;
            first         <= 1'b0;
         end
         // single beat packets go back to first here as well
         if (take && in_beat.last) begin
            first <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take && first) begin
         tx_meta <= in_beat.session;
      end
   end

endmodule

`default_nettype wire
